// ==== src/adc_rx_params.svh ====
/* ADC capture parameters
   sample and counter widths, memory depths, channel count and version */
`ifndef ADC_RX_PARAMS_SVH
`define ADC_RX_PARAMS_SVH

`define ADC_WIDTH   14  // bits per sample
`define CNT_WIDTH   24  // record length counter
`define DLY_DEPTH   256 // delay memory entries
`define FIFO_AW     6   // 64 word output fifo

`define NUM_CH      2
`define ADC_VERSION 1

`endif

// ==== src/adc_cfg_pkg.sv ====
/* ADC capture configuration types
   register addresses and the decoded configuration set */
`include "adc_rx_params.svh"
`default_nettype none

package adc_cfg_pkg;

    // byte wide register map
    typedef enum logic [3:0] {
        RESET_VERSION = 4'd0, // write: soft reset, read: version
        START_DONE    = 4'd1, // write: start, read: done
        CONF_FLAGS    = 4'd2,
        CNT_0         = 4'd3, // data count, low byte
        CNT_1         = 4'd4,
        CNT_2         = 4'd5,
        SAMPLE_DLY    = 4'd6,
        LOST_0        = 4'd8,
        LOST_1        = 4'd9
    } reg_addr_e;

    typedef struct packed {
        logic                  start_with_sync; // flag bit 0
        logic                  en_ex_trigger;   // flag bit 1
        logic                  single_data;     // flag bit 2
        logic [`CNT_WIDTH-1:0] data_cnt;        // 0 records forever
        logic [7:0]            sample_dly;
    } adc_cfg_t;

endpackage

`default_nettype wire

// ==== src/adc_data_pkg.sv ====
/* ADC capture data types
   output word layout, channel slot and capture states */
`include "adc_rx_params.svh"
`default_nettype none

package adc_data_pkg;

    localparam logic HEADER_ID = 1'b0;

    // one fifo word, 32 bits
    typedef struct packed {
        logic                  header;
        logic [1:0]            chan_id;
        logic                  flag;        // sync or first sample
        logic [`ADC_WIDTH-1:0] prev_sample; // zero in single mode
        logic [`ADC_WIDTH-1:0] sample;
    } adc_word_t;

    // output slot of one channel
    typedef struct packed {
        logic      pending;
        adc_word_t word;
    } chan_out_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_SYNC, // start seen, waiting for sync edge
        RECORD
    } cap_state_e;

endpackage

`default_nettype wire

// ==== src/adc_rx_regs.sv ====
/* ADC capture register file
   configuration bytes, start and soft reset pulses, done status and read-back */
`include "adc_rx_params.svh"
`default_nettype none

module adc_rx_regs (
    input  wire logic                   ADC_ENC,
    input  wire logic                   RST,
    input  wire logic [3:0]             bus_add,
    input  wire logic                   bus_wr,
    input  wire logic                   bus_rd,
    input  wire logic [7:0]             bus_data_in,
    input  wire logic [`NUM_CH-1:0]     finished,
    input  wire logic [7:0]             lost_cnt0,
    input  wire logic [7:0]             lost_cnt1,
    output logic [7:0]                  bus_data_out,
    output adc_cfg_pkg::adc_cfg_t       cfg,
    output logic                        start,
    output logic                        clear
);
    import adc_cfg_pkg::*;

    reg_addr_e             addr;
    logic                  soft_wr;
    logic                  start_wr;
    logic [2:0]            conf_flags;
    logic [`CNT_WIDTH-1:0] data_cnt;
    logic [7:0]            sample_dly;
    logic                  done;
    logic [`NUM_CH-1:0]    fin_seen; // sticky per channel since start

    assign addr     = reg_addr_e'(bus_add);
    assign soft_wr  = bus_wr && (addr == RESET_VERSION);
    assign start_wr = bus_wr && (addr == START_DONE);

    always_comb begin
        cfg.start_with_sync = conf_flags[0];
        cfg.en_ex_trigger   = conf_flags[1];
        cfg.single_data     = conf_flags[2];
        cfg.data_cnt        = data_cnt;
        cfg.sample_dly      = sample_dly;
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST || soft_wr) begin
            conf_flags <= '0;
            data_cnt   <= '0;
            sample_dly <= 8'd1;
        end else if (bus_wr) begin
            case (addr)
                CONF_FLAGS: conf_flags      <= bus_data_in[2:0];
                CNT_0:      data_cnt[7:0]   <= bus_data_in;
                CNT_1:      data_cnt[15:8]  <= bus_data_in;
                CNT_2:      data_cnt[23:16] <= bus_data_in;
                SAMPLE_DLY: sample_dly      <= bus_data_in;
                default:    ;
            endcase
        end
    end

    // pulses reach the channels one cycle after the write
    always_ff @(posedge ADC_ENC) begin
        if (RST) begin
            start <= 1'b0;
            clear <= 1'b1;
        end else begin
            start <= start_wr;
            clear <= soft_wr;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST || soft_wr) begin
            done     <= 1'b1;
            fin_seen <= '0;
        end else if (start) begin
            done     <= 1'b0;
            fin_seen <= '0;
        end else begin
            fin_seen <= fin_seen | finished;
            if (&(fin_seen | finished))
                done <= 1'b1; // every channel reached its count
        end
    end

    // read data holds between reads
    always_ff @(posedge ADC_ENC) begin
        if (bus_rd) begin
            case (addr)
                RESET_VERSION: bus_data_out <= 8'(`ADC_VERSION);
                START_DONE:    bus_data_out <= {7'd0, done};
                CONF_FLAGS:    bus_data_out <= {5'd0, conf_flags};
                CNT_0:         bus_data_out <= data_cnt[7:0];
                CNT_1:         bus_data_out <= data_cnt[15:8];
                CNT_2:         bus_data_out <= data_cnt[23:16];
                SAMPLE_DLY:    bus_data_out <= sample_dly;
                LOST_0:        bus_data_out <= lost_cnt0;
                LOST_1:        bus_data_out <= lost_cnt1;
                default:       bus_data_out <= 8'd0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/adc_rx_capture.sv ====
/* ADC capture channel
   delays the sample stream, records on start, sync or trigger and packs output words */
`include "adc_rx_params.svh"
`default_nettype none

module adc_rx_capture #(
    parameter logic [1:0] CHAN_ID = 2'd0
) (
    input  wire logic                    ADC_ENC,
    input  wire logic                    RST,
    input  wire logic                    clear,
    input  wire logic                    start,
    input  wire adc_cfg_pkg::adc_cfg_t   cfg,
    input  wire logic                    adc_sync,
    input  wire logic                    adc_trigger,
    input  wire logic [`ADC_WIDTH-1:0]   adc_in,
    input  wire logic                    grant,
    output adc_data_pkg::chan_out_t      chan_out,
    output logic                         finished,
    output logic [7:0]                   lost_cnt
);
    import adc_data_pkg::*;

    localparam int DLY_AW = $clog2(`DLY_DEPTH);

    logic [`ADC_WIDTH-1:0] dly_mem [`DLY_DEPTH];
    logic [DLY_AW-1:0]     wr_ptr;
    logic [DLY_AW-1:0]     rd_ptr;
    logic [`ADC_WIDTH-1:0] dly_sample;

    cap_state_e            state;
    logic [`CNT_WIDTH-1:0] rec_cnt;
    logic [`CNT_WIDTH-1:0] cur_idx;
    logic                  sync_q;
    logic                  sync_rise;
    logic                  first;  // first sample of a record
    logic                  rec_active;
    logic                  last;

    logic                  flag_now;
    logic                  flag_q;
    logic [`ADC_WIDTH-1:0] prev_q;
    logic                  word_valid;
    adc_word_t             new_word;
    adc_word_t             slot_word;
    logic                  pending;

    // delay line, async read gives exactly sample_dly cycles
    always_ff @(posedge ADC_ENC) begin
        if (RST)
            wr_ptr <= '0;
        else
            wr_ptr <= wr_ptr + 1'b1;
    end

    always_ff @(posedge ADC_ENC)
        dly_mem[wr_ptr] <= adc_in;

    assign rd_ptr     = wr_ptr - cfg.sample_dly;
    assign dly_sample = (cfg.sample_dly == 8'd0) ? adc_in : dly_mem[rd_ptr];

    assign sync_rise = adc_sync && !sync_q;

    always_comb begin
        first = (start && !cfg.start_with_sync) ||
                (state == WAIT_SYNC && sync_rise) ||
                (state == IDLE && cfg.en_ex_trigger && adc_trigger);
        rec_active = first || (state == RECORD && !start); // a new start restarts
        cur_idx    = first ? '0 : rec_cnt;
        last       = (cfg.data_cnt != '0) && (cur_idx == cfg.data_cnt - 1'b1);
    end

    always_ff @(posedge ADC_ENC) begin
        if (RST || clear) begin
            state    <= IDLE;
            rec_cnt  <= '0;
            finished <= 1'b0;
            sync_q   <= 1'b0;
        end else begin
            sync_q   <= adc_sync;
            finished <= 1'b0;
            if (rec_active) begin
                if (last) begin
                    state    <= IDLE;
                    finished <= 1'b1;
                end else begin
                    state   <= RECORD;
                    rec_cnt <= cur_idx + 1'b1;
                end
            end else if (start && cfg.start_with_sync) begin
                state <= WAIT_SYNC;
            end
        end
    end

    // packing, double mode writes on every odd sample index
    assign flag_now   = cfg.en_ex_trigger ? first : adc_sync;
    assign word_valid = rec_active && (cfg.single_data || cur_idx[0]);

    always_ff @(posedge ADC_ENC) begin
        prev_q <= dly_sample;
        flag_q <= flag_now;
    end

    always_comb begin
        new_word.header      = HEADER_ID;
        new_word.chan_id     = CHAN_ID;
        new_word.flag        = cfg.single_data ? flag_now : flag_q;
        new_word.prev_sample = cfg.single_data ? '0 : prev_q;
        new_word.sample      = dly_sample;
    end

    // output slot, a busy slot drops the new word
    always_ff @(posedge ADC_ENC) begin
        if (RST || clear) begin
            pending  <= 1'b0;
            lost_cnt <= 8'd0;
        end else begin
            if (word_valid && (!pending || grant))
                pending <= 1'b1;
            else if (grant)
                pending <= 1'b0;
            if (word_valid && pending && !grant && lost_cnt != 8'hff)
                lost_cnt <= lost_cnt + 1'b1;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (word_valid && (!pending || grant))
            slot_word <= new_word;
    end

    assign chan_out.pending = pending;
    assign chan_out.word    = slot_word;

endmodule

`default_nettype wire

// ==== src/adc_fifo_arbiter.sv ====
/* Channel arbiter and output FIFO
   round-robin grant of channel slots into a 64 word show-ahead FIFO */
`include "adc_rx_params.svh"
`default_nettype none

module adc_fifo_arbiter (
    input  wire logic                     ADC_ENC,
    input  wire logic                     RST,
    input  wire logic                     clear,
    input  wire adc_data_pkg::chan_out_t  chan0,
    input  wire adc_data_pkg::chan_out_t  chan1,
    input  wire logic                     fifo_read,
    output logic [`NUM_CH-1:0]            grant,
    output adc_data_pkg::adc_word_t       fifo_data,
    output logic                          fifo_empty
);
    import adc_data_pkg::*;

    localparam int AW = `FIFO_AW;

    adc_word_t          mem [2**AW];
    logic [AW:0]        wr_ptr;
    logic [AW:0]        rd_ptr;
    logic               full;
    logic               wr_en;
    logic               rd_en;
    adc_word_t          wr_word;
    logic [`NUM_CH-1:0] pend;
    logic               rr; // channel with priority

    assign pend = {chan1.pending, chan0.pending};

    // extra pointer bit tells full from empty
    assign full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);

    always_comb begin
        grant = '0;
        if (!full) begin
            if (pend[rr])
                grant[rr] = 1'b1;
            else if (pend[~rr])
                grant[~rr] = 1'b1;
        end
    end

    assign wr_en   = |grant;
    assign rd_en   = fifo_read && !fifo_empty; // read on empty ignored
    assign wr_word = grant[1] ? chan1.word : chan0.word;

    always_ff @(posedge ADC_ENC) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rr     <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                rr     <= grant[0]; // other channel goes first next time
            end
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge ADC_ENC) begin
        if (wr_en)
            mem[wr_ptr[AW-1:0]] <= wr_word;
    end

    // head word shown without a read
    assign fifo_data = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

// ==== src/adc_rx_top.sv ====
/* Two channel ADC capture top level
   register bus, two capture channels and the shared output FIFO */
`include "adc_rx_params.svh"
`default_nettype none

module adc_rx_top (
    input  wire logic                  ADC_ENC,
    input  wire logic                  RST,
    input  wire logic [3:0]            bus_add,
    input  wire logic                  bus_wr,
    input  wire logic                  bus_rd,
    input  wire logic [7:0]            bus_data_in,
    output logic [7:0]                 bus_data_out,
    input  wire logic [`ADC_WIDTH-1:0] adc_in0,
    input  wire logic [`ADC_WIDTH-1:0] adc_in1,
    input  wire logic                  adc_sync,
    input  wire logic                  adc_trigger,
    input  wire logic                  fifo_read,
    output logic                       fifo_empty,
    output adc_data_pkg::adc_word_t    fifo_data,
    output logic                       lost_error
);
    import adc_cfg_pkg::*;
    import adc_data_pkg::*;

    adc_cfg_t           cfg;
    logic               start;
    logic               clear;
    logic [`NUM_CH-1:0] finished;
    logic [`NUM_CH-1:0] grant;
    logic [7:0]         lost_cnt0;
    logic [7:0]         lost_cnt1;
    chan_out_t          chan0;
    chan_out_t          chan1;

    assign lost_error = (lost_cnt0 != 8'd0) || (lost_cnt1 != 8'd0);

    adc_rx_regs u_regs (
        .ADC_ENC, .RST, .bus_add, .bus_wr, .bus_rd, .bus_data_in, .finished,
        .lost_cnt0, .lost_cnt1, .bus_data_out, .cfg, .start, .clear
    );

    adc_rx_capture #(.CHAN_ID(2'd0)) u_cap0 (
        .ADC_ENC, .RST, .clear, .start, .cfg, .adc_sync, .adc_trigger,
        .adc_in(adc_in0), .grant(grant[0]), .chan_out(chan0),
        .finished(finished[0]), .lost_cnt(lost_cnt0)
    );

    adc_rx_capture #(.CHAN_ID(2'd1)) u_cap1 (
        .ADC_ENC, .RST, .clear, .start, .cfg, .adc_sync, .adc_trigger,
        .adc_in(adc_in1), .grant(grant[1]), .chan_out(chan1),
        .finished(finished[1]), .lost_cnt(lost_cnt1)
    );

    adc_fifo_arbiter u_arb (
        .ADC_ENC, .RST, .clear, .chan0, .chan1, .fifo_read,
        .grant, .fifo_data, .fifo_empty
    );

endmodule

`default_nettype wire

// ==== dv/adc_rx_asserts.sv ====
/* ADC capture port checks
   concurrent assertions bound to the top level */
`default_nettype none

module adc_rx_asserts (
    input wire logic       ADC_ENC,
    input wire logic       RST,
    input wire logic       bus_rd,
    input wire logic [7:0] bus_data_out,
    input wire logic       fifo_empty,
    input wire logic       lost_error,
    input wire logic [7:0] lost_cnt0,
    input wire logic [7:0] lost_cnt1
);
    timeunit 1ns;
    timeprecision 1ps;

    // fifo comes out of reset empty
    empty_after_reset: assert property (
        @(posedge ADC_ENC) RST |=> fifo_empty
    ) else $error("fifo not empty after reset");

    lost_error_match: assert property (
        @(posedge ADC_ENC) disable iff (RST)
        lost_error == ((lost_cnt0 != 8'd0) || (lost_cnt1 != 8'd0))
    ) else $error("lost_error does not follow the lost counters");

    // read data only moves after a read
    read_data_hold: assert property (
        @(posedge ADC_ENC) disable iff (RST)
        !$past(bus_rd) |-> $stable(bus_data_out)
    ) else $error("bus_data_out changed without a read");

endmodule

`default_nettype wire

// ==== dv/adc_rx_tb.sv ====
/* ADC capture testbench
   bus setup, ramp and sync stimulus, FIFO readout and word checks */
`include "adc_rx_params.svh"
`default_nettype none

module adc_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import adc_cfg_pkg::*;
    import adc_data_pkg::*;

    logic        ADC_ENC = 1'b0;
    logic        RST;
    logic [3:0]  bus_add;
    logic        bus_wr;
    logic        bus_rd;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic [13:0] adc_in0 = '0;
    logic [13:0] adc_in1 = '0;
    logic        adc_sync = 1'b0;
    logic        adc_trigger;
    logic        fifo_read;
    logic        fifo_empty;
    adc_word_t   fifo_data;
    logic        lost_error;

    logic [13:0] ramp = '0;
    logic [31:0] rng = 32'h5387_55d6;
    int          gap = 6;
    int          sync_count = 0;
    bit          sync_mark [16384]; // ramp values that saw a sync pulse
    adc_word_t   q0[$];
    adc_word_t   q1[$];

    adc_rx_top u_dut (.*);

    bind adc_rx_top adc_rx_asserts u_asserts (
        .ADC_ENC(ADC_ENC), .RST(RST), .bus_rd(bus_rd), .bus_data_out(bus_data_out),
        .fifo_empty(fifo_empty), .lost_error(lost_error),
        .lost_cnt0(lost_cnt0), .lost_cnt1(lost_cnt1)
    );

    always #4 ADC_ENC = ~ADC_ENC;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ramp on both channels and sync at random gaps
    always @(posedge ADC_ENC) begin
        ramp    <= ramp + 14'd1;
        adc_in0 <= ramp;
        adc_in1 <= ramp + 14'h1000;
        if (gap == 0) begin
            adc_sync <= 1'b1;
            sync_mark[ramp] = 1'b1;
            sync_count <= sync_count + 1;
            rng = xorshift32(rng);
            gap <= 4 + int'(rng % 32'd16);
        end else begin
            adc_sync <= 1'b0;
            gap      <= gap - 1;
        end
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_now($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic check_true(input bit cond, input string why);
        assert (cond) else fail_now(why);
    endtask

    task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
        @(posedge ADC_ENC);
        bus_add     <= a;
        bus_data_in <= d;
        bus_wr      <= 1'b1;
        @(posedge ADC_ENC);
        bus_wr      <= 1'b0;
    endtask

    task automatic bus_read(input logic [3:0] a, output logic [7:0] d);
        @(posedge ADC_ENC);
        bus_add <= a;
        bus_rd  <= 1'b1;
        @(posedge ADC_ENC);
        bus_rd  <= 1'b0;
        @(negedge ADC_ENC);
        d = bus_data_out;
    endtask

    // read words until the FIFO stays empty for a while
    task automatic drain();
        adc_word_t w;
        int        quiet;
        int        cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 60) begin
            cycles++;
            if (cycles > 2000)
                fail_now("timed out draining the FIFO");
            @(negedge ADC_ENC);
            if (!fifo_empty) begin
                w = fifo_data;
                check_eq("fifo_data.header", 32'(w.header), 32'd0);
                if (w.chan_id == 2'd0)
                    q0.push_back(w);
                else
                    q1.push_back(w);
                @(posedge ADC_ENC) fifo_read <= 1'b1;
                @(posedge ADC_ENC) fifo_read <= 1'b0;
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic wait_done();
        logic [7:0] d;
        int         n;
        n = 0;
        bus_read(START_DONE, d);
        while (!d[0]) begin
            n++;
            if (n > 200)
                fail_now("timed out waiting for the done bit");
            bus_read(START_DONE, d);
        end
    endtask

    task automatic soft_reset();
        bus_write(RESET_VERSION, 8'd0);
        q0.delete();
        q1.delete();
    endtask

    initial begin
        logic [7:0]  d;
        logic [7:0]  l0;
        logic [7:0]  l1;
        logic [7:0]  p0;
        logic [7:0]  p1;
        logic [13:0] idx;
        int          n;
        int          s0;
        RST         = 1'b1;
        bus_add     = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        bus_data_in = '0;
        adc_trigger = 1'b0;
        fifo_read   = 1'b0;
        repeat (16) @(posedge ADC_ENC);
        RST <= 1'b0;
        repeat (4) @(posedge ADC_ENC);

        // version, done and empty fifo after reset
        bus_read(RESET_VERSION, d);
        check_eq("bus_data_out", 32'(d), 32'(`ADC_VERSION));
        bus_read(START_DONE, d);
        check_eq("done", 32'(d), 32'd1);
        @(negedge ADC_ENC);
        check_eq("fifo_empty", 32'(fifo_empty), 32'd1);

        // double mode over 16 samples
        bus_write(CNT_0, 8'd16);
        bus_write(CONF_FLAGS, 8'd0);
        bus_write(START_DONE, 8'd0);
        drain();
        check_eq("q0.size", 32'(q0.size()), 32'd8);
        check_eq("q1.size", 32'(q1.size()), 32'd8);
        for (int i = 0; i < 8; i++) begin
            check_eq("ch0 sample", 32'(q0[i].sample), 32'(14'(q0[i].prev_sample + 14'd1)));
            check_eq("ch1 sample", 32'(q1[i].sample), 32'(14'(q1[i].prev_sample + 14'd1)));
            check_eq("ch1 offset", 32'(q1[i].sample), 32'(14'(q0[i].sample + 14'h1000)));
            if (i > 0)
                check_eq("ch0 step", 32'(q0[i].sample), 32'(14'(q0[i-1].sample + 14'd2)));
        end
        wait_done();

        // single mode with delay 5 where flagged words line up with sync
        soft_reset();
        bus_write(SAMPLE_DLY, 8'd5);
        bus_write(CNT_0, 8'd32);
        bus_write(CONF_FLAGS, 8'd4);
        bus_write(START_DONE, 8'd0);
        drain();
        n = 0;
        foreach (q0[i]) begin
            if (q0[i].flag) begin
                idx = q0[i].sample + 14'd5;
                check_true(sync_mark[idx], "channel 0 flagged word is not delayed by 5");
                n++;
            end
        end
        foreach (q1[i]) begin
            if (q1[i].flag) begin
                idx = q1[i].sample + 14'd5 - 14'h1000;
                check_true(sync_mark[idx], "channel 1 flagged word is not delayed by 5");
                n++;
            end
        end
        check_true(n > 0, "no flagged word arrived in the delay test");

        // start waits for sync
        soft_reset();
        bus_write(CNT_0, 8'd8);
        bus_write(CONF_FLAGS, 8'd5);
        bus_write(START_DONE, 8'd0);
        @(negedge ADC_ENC);
        s0 = sync_count;
        n = 0;
        while (fifo_empty) begin
            n++;
            if (n > 200)
                fail_now("timed out waiting for a word after sync");
            @(negedge ADC_ENC);
        end
        check_true(sync_count > s0, "word arrived before the sync edge");
        drain();
        check_true(q0.size() > 0 && q1.size() > 0, "a channel sent no word after sync");
        check_eq("ch0 flag", 32'(q0[0].flag), 32'd1);
        check_eq("ch1 flag", 32'(q1[0].flag), 32'd1);

        // endless record without reads
        soft_reset();
        bus_write(CONF_FLAGS, 8'd4);
        bus_write(START_DONE, 8'd0);
        n = 0;
        while (!lost_error) begin
            n++;
            if (n > 1000)
                fail_now("timed out waiting for lost_error");
            @(negedge ADC_ENC);
        end
        p0 = '0;
        p1 = '0;
        n  = 0;
        do begin
            n++;
            if (n > 400)
                fail_now("lost counters did not reach 255");
            bus_read(LOST_0, l0);
            bus_read(LOST_1, l1);
            check_true(l0 >= p0 && l1 >= p1, "lost counter went backwards");
            p0 = l0;
            p1 = l1;
        end while (l0 != 8'hff || l1 != 8'hff);
        repeat (300) @(posedge ADC_ENC);
        bus_read(LOST_0, l0);
        check_eq("lost_cnt0", 32'(l0), 32'hff);
        bus_read(LOST_1, l1);
        check_eq("lost_cnt1", 32'(l1), 32'hff);
        soft_reset();
        bus_read(LOST_0, l0);
        check_eq("lost_cnt0", 32'(l0), 32'd0);
        bus_read(LOST_1, l1);
        check_eq("lost_cnt1", 32'(l1), 32'd0);
        @(negedge ADC_ENC);
        check_eq("fifo_empty", 32'(fifo_empty), 32'd1);

        // external trigger starts 8 samples in double mode
        bus_write(CNT_0, 8'd8);
        bus_write(CONF_FLAGS, 8'd2);
        @(posedge ADC_ENC) adc_trigger <= 1'b1;
        @(posedge ADC_ENC) adc_trigger <= 1'b0;
        drain();
        check_eq("q0.size", 32'(q0.size()), 32'd4);
        check_eq("q1.size", 32'(q1.size()), 32'd4);
        check_eq("ch0 flag", 32'(q0[0].flag), 32'd1);
        check_eq("ch1 flag", 32'(q1[0].flag), 32'd1);

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/adc_cfg_pkg.sv
src/adc_data_pkg.sv
src/adc_rx_regs.sv
src/adc_rx_capture.sv
src/adc_fifo_arbiter.sv
src/adc_rx_top.sv
dv/adc_rx_asserts.sv
dv/adc_rx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ADC capture testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module adc_rx_tb -o adc_rx_sim
./obj_dir/adc_rx_sim
